//--- Bender.yml
package:
  name: asym_fifo

sources:
  # synthesizable design, compile order matters for the package
  - files:
      - design/asym_fifo_pkg.sv
      - design/asym_mem_if.sv
      - design/asym_converter.sv
      - design/lane_ram.sv
      - design/asym_fifo_ctrl.sv
      - design/asym_fifo_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/asym_fifo_props.sv
      - sim/tb_asym_fifo.sv

//--- asym_fifo.f
design/asym_fifo_pkg.sv
design/asym_mem_if.sv
design/asym_converter.sv
design/lane_ram.sv
design/asym_fifo_ctrl.sv
design/asym_fifo_top.sv
sim/asym_fifo_props.sv
sim/tb_asym_fifo.sv

//--- design/asym_converter.sv
`timescale 1ns/1ps

module asym_converter #(
   parameter int W_DATA_W  = 8,
   parameter int R_DATA_W  = 32,
   // address width in narrow items
   parameter int ADDR_W    = 6,
   localparam int MAXDATA_W = asym_fifo_pkg::max_w(W_DATA_W, R_DATA_W),
   localparam int MINDATA_W = asym_fifo_pkg::min_w(W_DATA_W, R_DATA_W),
   localparam int R         = asym_fifo_pkg::ratio(W_DATA_W, R_DATA_W),
   localparam int MINADDR_W = ADDR_W - $clog2(R),
   localparam int W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   localparam int SEL_W     = (R > 1) ? $clog2(R) : 1
) (
   input  logic                clk_i,
   input  logic                rst_n_i,

   // logical write port
   input  logic                w_en_i,
   input  logic [W_ADDR_W-1:0] w_addr_i,
   input  logic [W_DATA_W-1:0] w_data_i,

   // logical read port
   input  logic                r_en_i,
   input  logic [R_ADDR_W-1:0] r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o,

   asym_mem_if.conv            mem
);

   generate
      if (W_DATA_W > R_DATA_W) begin : g_write_wider
         logic [SEL_W-1:0] r_sel_q;

         // wide write fills every lane of the row
         assign mem.w_en   = {R{w_en_i}};
         assign mem.w_addr = w_addr_i;
         assign mem.w_data = w_data_i;

         // narrow read: low address bits pick the lane
         assign mem.r_en   = R'(r_en_i) << r_addr_i[SEL_W-1:0];
         assign mem.r_addr = r_addr_i[R_ADDR_W-1:SEL_W];

         // lane select follows the ram by one cycle
         always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
               r_sel_q <= '0;
            end else if (r_en_i) begin
               r_sel_q <= r_addr_i[SEL_W-1:0];
            end
         end

         assign r_data_o = mem.r_data[r_sel_q*MINDATA_W +: MINDATA_W];

      end else if (W_DATA_W < R_DATA_W) begin : g_read_wider
         // narrow write lands in one lane, data shifted into place
         assign mem.w_en   = R'(w_en_i) << w_addr_i[SEL_W-1:0];
         assign mem.w_data = MAXDATA_W'(w_data_i) << (w_addr_i[SEL_W-1:0] * MINDATA_W);
         assign mem.w_addr = w_addr_i[W_ADDR_W-1:SEL_W];

         // wide read takes the full row
         assign mem.r_en   = {R{r_en_i}};
         assign mem.r_addr = r_addr_i;
         assign r_data_o   = mem.r_data;

      end else begin : g_same_width
         // single lane, straight mapping
         assign mem.w_en   = w_en_i;
         assign mem.w_addr = w_addr_i;
         assign mem.w_data = w_data_i;

         assign mem.r_en   = r_en_i;
         assign mem.r_addr = r_addr_i;
         assign r_data_o   = mem.r_data;
      end
   endgenerate

endmodule

//--- design/asym_fifo_ctrl.sv
`timescale 1ns/1ps

module asym_fifo_ctrl #(
   parameter int W_DATA_W  = 8,
   parameter int R_DATA_W  = 32,
   parameter int ADDR_W    = 6,
   localparam int MAXDATA_W = asym_fifo_pkg::max_w(W_DATA_W, R_DATA_W),
   localparam int R         = asym_fifo_pkg::ratio(W_DATA_W, R_DATA_W),
   localparam int MINADDR_W = ADDR_W - $clog2(R),
   localparam int W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  logic                w_en_i,
   input  logic                r_en_i,

   output logic [W_ADDR_W-1:0] w_addr_o,
   output logic [R_ADDR_W-1:0] r_addr_o,
   output logic                w_push_o,
   output logic                r_pop_o,

   output logic                full_o,
   output logic                empty_o,
   output logic                r_valid_o,
   output logic [ADDR_W:0]     level_o
);

   import asym_fifo_pkg::*;

   localparam int MINDATA_W = min_w(W_DATA_W, R_DATA_W);
   localparam int DEPTH     = 2 ** ADDR_W;

   // item sizes in narrow units
   localparam logic [ADDR_W:0] W_INC    = (ADDR_W + 1)'(W_DATA_W / MINDATA_W);
   localparam logic [ADDR_W:0] R_DEC    = (ADDR_W + 1)'(R_DATA_W / MINDATA_W);
   localparam logic [ADDR_W:0] FULL_LVL = (ADDR_W + 1)'(DEPTH) - W_INC;

   logic [W_ADDR_W-1:0] w_ptr_q;
   logic [R_ADDR_W-1:0] r_ptr_q;
   logic [ADDR_W:0]     level_q;
   logic [ADDR_W:0]     level_d;
   rd_state_e           rd_state_q;
   rd_state_e           rd_state_d;

   // flags ignore requests outside the limits
   assign w_push_o = w_en_i & ~full_o;
   assign r_pop_o  = r_en_i & ~empty_o;

   always_comb begin
      level_d = level_q;
      if (w_push_o) begin
         level_d = level_d + W_INC;
      end
      if (r_pop_o) begin
         level_d = level_d - R_DEC;
      end
   end

   // pointers wrap at the depth by width
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (w_push_o) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (r_pop_o) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
         level_q <= level_d;
      end
   end

   // data shows up one cycle after the pop
   assign rd_state_d = r_pop_o ? RD_DATA : RD_IDLE;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_state_q <= RD_IDLE;
      end else begin
         rd_state_q <= rd_state_d;
      end
   end

   assign r_valid_o = (rd_state_q == RD_DATA);

   assign w_addr_o = w_ptr_q;
   assign r_addr_o = r_ptr_q;
   assign level_o  = level_q;

   // less room than one write item
   assign full_o  = (level_q > FULL_LVL);
   // less data than one read item
   assign empty_o = (level_q < R_DEC);

endmodule

//--- design/asym_fifo_pkg.sv
package asym_fifo_pkg;

   // default port widths and depth
   localparam int W_DATA_W_DEF = 8;
   localparam int R_DATA_W_DEF = 32;
   // depth counted in narrow items
   localparam int ADDR_W_DEF   = 6;

   // read data stage of the controller
   typedef enum logic {
      RD_IDLE = 1'b0,
      RD_DATA = 1'b1
   } rd_state_e;

   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // how many narrow items fit in one wide item
   function automatic int ratio(input int a, input int b);
      return max_w(a, b) / min_w(a, b);
   endfunction

endpackage

//--- design/asym_fifo_top.sv
`timescale 1ns/1ps

module asym_fifo_top #(
   parameter int W_DATA_W = asym_fifo_pkg::W_DATA_W_DEF,
   parameter int R_DATA_W = asym_fifo_pkg::R_DATA_W_DEF,
   parameter int ADDR_W   = asym_fifo_pkg::ADDR_W_DEF
) (
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   output logic                full_o,

   input  logic                r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_valid_o,
   output logic                empty_o,

   output logic [ADDR_W:0]     level_o
);

   import asym_fifo_pkg::*;

   localparam int MAXDATA_W = max_w(W_DATA_W, R_DATA_W);
   localparam int R         = ratio(W_DATA_W, R_DATA_W);
   localparam int MINADDR_W = ADDR_W - $clog2(R);
   localparam int W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
   localparam int R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;

   logic                w_push;
   logic                r_pop;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;

   asym_mem_if #(
      .R         (R),
      .MINADDR_W (MINADDR_W),
      .MAXDATA_W (MAXDATA_W)
   ) mem_if ();

   asym_fifo_ctrl #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) i_ctrl (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .w_en_i    (w_en_i),
      .r_en_i    (r_en_i),
      .w_addr_o  (w_addr),
      .r_addr_o  (r_addr),
      .w_push_o  (w_push),
      .r_pop_o   (r_pop),
      .full_o    (full_o),
      .empty_o   (empty_o),
      .r_valid_o (r_valid_o),
      .level_o   (level_o)
   );

   asym_converter #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) i_conv (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (w_push),
      .w_addr_i (w_addr),
      .w_data_i (w_data_i),
      .r_en_i   (r_pop),
      .r_addr_i (r_addr),
      .r_data_o (r_data_o),
      .mem      (mem_if.conv)
   );

   lane_ram #(
      .R         (R),
      .MINADDR_W (MINADDR_W),
      .MAXDATA_W (MAXDATA_W)
   ) i_ram (
      .clk_i (clk_i),
      .mem   (mem_if.mem)
   );

endmodule

//--- design/asym_mem_if.sv
`timescale 1ns/1ps

interface asym_mem_if #(
   parameter int R         = 4,
   parameter int MINADDR_W = 4,
   parameter int MAXDATA_W = 32
);

   // write side, one enable bit per lane
   logic [R-1:0]         w_en;
   logic [MINADDR_W-1:0] w_addr;
   logic [MAXDATA_W-1:0] w_data;

   // read side, data valid one cycle after r_en
   logic [R-1:0]         r_en;
   logic [MINADDR_W-1:0] r_addr;
   logic [MAXDATA_W-1:0] r_data;

   modport conv (
      output w_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   modport mem (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

//--- design/lane_ram.sv
`timescale 1ns/1ps

module lane_ram #(
   parameter int R         = 4,
   parameter int MINADDR_W = 4,
   parameter int MAXDATA_W = 32
) (
   input  logic   clk_i,
   asym_mem_if.mem mem
);

   localparam int MINDATA_W = MAXDATA_W / R;
   localparam int DEPTH     = 2 ** MINADDR_W;

   // one column per lane
   logic [MINDATA_W-1:0] ram_q [R][DEPTH];

   // lane columns written independently
   always_ff @(posedge clk_i) begin
      for (int l = 0; l < R; l++) begin
         if (mem.w_en[l]) begin
            ram_q[l][mem.w_addr] <= mem.w_data[l*MINDATA_W +: MINDATA_W];
         end
      end
   end

   // any lane enable loads the whole row
   // lanes not asked for are dropped by the converter
   always_ff @(posedge clk_i) begin
      if (|mem.r_en) begin
         for (int l = 0; l < R; l++) begin
            mem.r_data[l*MINDATA_W +: MINDATA_W] <= ram_q[l][mem.r_addr];
         end
      end
   end

endmodule

//--- sim/asym_fifo_props.sv
`timescale 1ns/1ps

module asym_fifo_props #(
   parameter int ADDR_W = 6
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     r_pop_i,
   input  logic                     r_valid_i,
   input  logic                     full_i,
   input  logic                     empty_i,
   input  logic [ADDR_W:0]          level_i
);

   localparam int DEPTH = 2 ** ADDR_W;

   // first cycle out of reset
   reset_flags_a: assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> (empty_i && !full_i))
      else $error("flags not in reset state after reset release");

   // valid only follows an accepted read
   valid_after_pop_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_valid_i |-> $past(r_pop_i))
      else $error("r_valid_o high without an accepted read one cycle before");

   pop_gives_valid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_pop_i |=> r_valid_i)
      else $error("accepted read not followed by r_valid_o");

   level_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      level_i <= (ADDR_W + 1)'(DEPTH))
      else $error("level above the FIFO depth");

   flags_excl_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(full_i && empty_i))
      else $error("full and empty flags both high");

endmodule

bind asym_fifo_ctrl asym_fifo_props #(
   .ADDR_W (ADDR_W)
) i_props (
   .clk_i      (clk_i),
   .rst_n_i    (rst_n_i),
   .r_pop_i    (r_pop_o),
   .r_valid_i  (r_valid_o),
   .full_i     (full_o),
   .empty_i    (empty_o),
   .level_i    (level_o)
);

//--- sim/tb_asym_fifo.sv
`timescale 1ns/1ps

module tb_asym_fifo;

   import asym_fifo_pkg::*;

   localparam int W_W      = W_DATA_W_DEF;
   localparam int R_W      = R_DATA_W_DEF;
   localparam int DEPTH    = 2 ** ADDR_W_DEF;
   // narrow items per read word
   localparam int RD_ITEMS = R_W / W_W;

   // phase lengths in cycles
   localparam int RST_CYCLES    = 10;
   localparam int DIRECT_CYCLES = 12;
   localparam int FILL_CYCLES   = 150;
   localparam int DRAIN_CYCLES  = 150;
   localparam int MIX_CYCLES    = 2000;
   localparam int FLUSH_CYCLES  = 40;
   localparam int TOTAL_CYCLES  = RST_CYCLES + DIRECT_CYCLES + FILL_CYCLES + DRAIN_CYCLES
                                  + MIX_CYCLES + FLUSH_CYCLES + 10;
   localparam int TIMEOUT       = 2 * TOTAL_CYCLES + 100;

   logic             clk;
   logic             rst_n;
   logic             w_en;
   logic [W_W-1:0]   w_data;
   logic             full;
   logic             r_en;
   logic [R_W-1:0]   r_data;
   logic             r_valid;
   logic             empty;
   logic [ADDR_W_DEF:0] level;

   integer           seed = 11483;
   int               cycle_cnt = 0;
   int               checks = 0;
   int               errors = 0;
   int               reads = 0;

   // model state
   logic [W_W-1:0]   byte_q[$];
   logic [R_W-1:0]   exp_word;
   logic             rd_pending = 1'b0;

   asym_fifo_top i_dut (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .w_en_i    (w_en),
      .w_data_i  (w_data),
      .full_o    (full),
      .r_en_i    (r_en),
      .r_data_o  (r_data),
      .r_valid_o (r_valid),
      .empty_o   (empty),
      .level_o   (level)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT);
         $display("Result: FAILED");
         $finish;
      end
   end

   // outputs sampled at the falling edge, inputs seen there are used at the next rise
   always @(negedge clk) begin : monitor
      if (rst_n) begin
         // response to the read accepted at the last rising edge
         if (rd_pending) begin
            checks++;
            if (!r_valid) begin
               errors++;
               $display("FAILED %0t: r_valid_o low one cycle after an accepted read", $time);
            end else if (r_data !== exp_word) begin
               errors++;
               $display("FAILED %0t: r_data_o %h, expected %h", $time, r_data, exp_word);
            end
         end else if (r_valid) begin
            errors++;
            $display("FAILED %0t: r_valid_o high with no read pending", $time);
         end

         checks++;
         if (level !== byte_q.size()) begin
            errors++;
            $display("FAILED %0t: level_o %0d, expected %0d", $time, level, byte_q.size());
         end
         if (empty !== (byte_q.size() < RD_ITEMS)) begin
            errors++;
            $display("FAILED %0t: empty_o %b with %0d items", $time, empty, byte_q.size());
         end
         if (full !== (byte_q.size() == DEPTH)) begin
            errors++;
            $display("FAILED %0t: full_o %b with %0d items", $time, full, byte_q.size());
         end

         // requests the DUT takes at the next rising edge
         rd_pending = 1'b0;
         if (r_en && !empty && byte_q.size() >= RD_ITEMS) begin
            // first byte goes to the lowest lane
            for (int i = 0; i < RD_ITEMS; i++) begin
               exp_word[i*W_W +: W_W] = byte_q.pop_front();
            end
            rd_pending = 1'b1;
            reads++;
         end
         if (w_en && !full) begin
            byte_q.push_back(w_data);
         end
      end
   end

   task automatic drive_traffic(input int n, input int w_pct, input int r_pct);
      int          rnd_w;
      int          rnd_r;
      logic [31:0] rnd_d;
      repeat (n) begin
         @(posedge clk);
         rnd_w = $unsigned($random(seed)) % 100;
         rnd_r = $unsigned($random(seed)) % 100;
         rnd_d = $random(seed);
         w_en   <= (rnd_w < w_pct);
         r_en   <= (rnd_r < r_pct);
         w_data <= rnd_d[W_W-1:0];
      end
   endtask

   // known bytes, then one word read
   task automatic write_then_read(input logic [W_W*RD_ITEMS-1:0] bytes);
      for (int i = 0; i < RD_ITEMS; i++) begin
         @(posedge clk);
         w_en   <= 1'b1;
         r_en   <= 1'b0;
         w_data <= bytes[i*W_W +: W_W];
      end
      @(posedge clk);
      w_en <= 1'b0;
      r_en <= 1'b1;
      @(posedge clk);
      r_en <= 1'b0;
   endtask

   initial begin
      rst_n  = 1'b0;
      w_en   = 1'b0;
      r_en   = 1'b0;
      w_data = '0;

      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      @(negedge clk);
      checks++;
      if (empty !== 1'b1 || full !== 1'b0 || level !== '0 || r_valid !== 1'b0) begin
         errors++;
         $display("FAILED %0t: reset state empty %b full %b level %0d valid %b",
                  $time, empty, full, level, r_valid);
      end

      write_then_read(32'h44332211);
      write_then_read(32'hdeadbeef);
      repeat (2) @(posedge clk);

      // overflow then underflow
      drive_traffic(FILL_CYCLES, 90, 5);
      drive_traffic(DRAIN_CYCLES, 5, 90);
      drive_traffic(MIX_CYCLES, 60, 50);
      drive_traffic(FLUSH_CYCLES, 0, 100);

      @(posedge clk);
      w_en <= 1'b0;
      r_en <= 1'b0;
      repeat (3) @(negedge clk);

      if (rd_pending) begin
         errors++;
         $display("read data still outstanding at the end of the run");
      end
      if (reads == 0) begin
         errors++;
         $display("no read was accepted during the run");
      end

      $display("checks %0d, reads %0d, errors %0d", checks, reads, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
